// File: sdLvsTop.f
+incdir+design
design/sdLvsPkg.sv
design/sdTickGen.sv
design/sdPadDriver.sv
design/lvsSequencer.sv
design/sdLvsRegs.sv
design/sdLvsTop.sv
dv/sdLvsTb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module sdLvsTb -f sdLvsTop.f > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/VsdLvsTb > sim.log 2>&1 || true
grep -q "Simulation completed successfully" sim.log && echo "PASS" \
    || { cat sim.log; echo "FAIL"; exit 1; }

// File: dv/sdLvsTb.sv
`timescale 1ns/1ps

`include "sdLvs_config.svh"

module sdLvsTb;
    import sdLvsPkg::*;

    localparam int waitLimit = 40000;

    typedef struct packed {
        logic [11:0] pulseTicks;
        logic [11:0] releaseTicks;
        logic        cardPresent;
        logic        expDetected;
    } rowT;

    // Pulse length, release delay, card present, expected detected
    localparam rowT rows [0:3] = '{
        '{12'd7,  12'd20, 1'b1, 1'b1},
        '{12'd1,  12'd1,  1'b0, 1'b0},
        '{12'd3,  12'd5,  1'b1, 1'b1},
        '{12'd10, 12'd4,  1'b0, 1'b0}
    };

    logic        clk;
    logic        rstN;
    axiLiteReqT  axiReq;
    axiLiteRespT axiResp;
    logic [3:0]  led;
    logic        sdClk;
    logic        sdCmdOut;
    logic        sdCmdOutEn;
    logic [3:0]  sdDatOut;
    logic [3:0]  sdDatOutEn;
    logic        sdCmdIn;
    logic [3:0]  sdDatIn;
    logic        cardPresent;
    logic        cardDrive;
    logic [31:0] lfsrState;

    sdLvsTop i_sdLvsTop (
        .clk        (clk),
        .rstN       (rstN),
        .axiReq     (axiReq),
        .axiResp    (axiResp),
        .led        (led),
        .sdClk      (sdClk),
        .sdCmdOut   (sdCmdOut),
        .sdCmdOutEn (sdCmdOutEn),
        .sdDatOut   (sdDatOut),
        .sdDatOutEn (sdDatOutEn),
        .sdCmdIn    (sdCmdIn),
        .sdDatIn    (sdDatIn)
    );

    always #4 clk = ~clk;

    // Card model drives DAT2 high once the host lets go
    // Undriven lines read 0 (pull-down)
    assign cardDrive = cardPresent && !sdDatOutEn[2];
    assign sdCmdIn   = sdCmdOutEn & sdCmdOut;
    assign sdDatIn   = (sdDatOutEn & sdDatOut) | {1'b0, cardDrive, 2'b00};

    // ========================================================================
    // Reporting and random delays
    // ========================================================================

    task automatic stopWithFail();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            stopWithFail();
        end
    endtask

    task automatic stepWait(inout int waitCnt, input string what);
        waitCnt++;
        if (waitCnt > waitLimit) begin
            $display("Timeout at %0t ns while waiting for %s", $time, what);
            stopWithFail();
        end
        @(negedge clk);
    endtask

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic drawBits(input int nBits, output int value);
        value = 0;
        for (int i = 0; i < nBits; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // ========================================================================
    // AXI4-Lite master
    // ========================================================================

    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int bDelay,
                            output logic [1:0] resp);
        int waitCnt;
        @(posedge clk);
        axiReq.awaddr  <= addr;
        axiReq.awvalid <= 1'b1;
        axiReq.wdata   <= data;
        axiReq.wstrb   <= strb;
        axiReq.wvalid  <= 1'b1;
        axiReq.bready  <= 1'b0;
        waitCnt = 0;
        @(negedge clk);
        while (!axiResp.awready) stepWait(waitCnt, "write address accept");
        checkValue(32'(axiResp.wready), 32'h1, "wready with awready");
        @(posedge clk);
        axiReq.awvalid <= 1'b0;
        axiReq.wvalid  <= 1'b0;
        waitCnt = 0;
        @(negedge clk);
        while (!axiResp.bvalid) stepWait(waitCnt, "write response");
        resp = axiResp.bresp;
        // Response must hold while bready stays low
        repeat (bDelay) begin
            @(negedge clk);
            checkValue(32'(axiResp.bvalid), 32'h1, "bvalid under back-pressure");
            checkValue(32'(axiResp.bresp), 32'(resp), "bresp under back-pressure");
        end
        @(posedge clk);
        axiReq.bready <= 1'b1;
        @(posedge clk);
        axiReq.bready <= 1'b0;
    endtask

    task automatic axiRead(input logic [3:0] addr, input int rDelay,
                           output logic [31:0] data, output logic [1:0] resp);
        int waitCnt;
        @(posedge clk);
        axiReq.araddr  <= addr;
        axiReq.arvalid <= 1'b1;
        axiReq.rready  <= 1'b0;
        waitCnt = 0;
        @(negedge clk);
        while (!axiResp.arready) stepWait(waitCnt, "read address accept");
        @(posedge clk);
        axiReq.arvalid <= 1'b0;
        waitCnt = 0;
        @(negedge clk);
        while (!axiResp.rvalid) stepWait(waitCnt, "read data");
        data = axiResp.rdata;
        resp = axiResp.rresp;
        repeat (rDelay) begin
            @(negedge clk);
            checkValue(32'(axiResp.rvalid), 32'h1, "rvalid under back-pressure");
            checkValue(axiResp.rdata, data, "rdata under back-pressure");
            checkValue(32'(axiResp.rresp), 32'(resp), "rresp under back-pressure");
        end
        @(posedge clk);
        axiReq.rready <= 1'b1;
        @(posedge clk);
        axiReq.rready <= 1'b0;
    endtask

    // ========================================================================
    // One identification run
    // ========================================================================

    task automatic runRow(input rowT row);
        int          waitCnt;
        int          highCnt;
        int          delay;
        logic [31:0] rdData;
        logic [1:0]  resp;
        logic [31:0] expStatus;
        drawBits(2, delay);
        axiWrite(`REG_PULSE, 32'(row.pulseTicks), 4'hF, delay, resp);
        drawBits(2, delay);
        axiWrite(`REG_RELEASE, 32'(row.releaseTicks), 4'hF, delay, resp);
        @(posedge clk);
        cardPresent <= row.cardPresent;
        axiWrite(`REG_CTRL, 32'h1, 4'hF, 0, resp);

        // All enables on through the drive-low phase
        waitCnt = 0;
        @(negedge clk);
        while (sdDatOutEn != 4'hF) stepWait(waitCnt, "drive-low phase");
        while (!sdClk) begin
            checkValue(32'(sdDatOutEn), 32'hF, "DAT enables before pulse");
            checkValue(32'(sdCmdOutEn), 32'h1, "CMD enable before pulse");
            checkValue(32'({sdCmdOut, sdDatOut}), 32'h0, "CMD and DAT driven low");
            stepWait(waitCnt, "sdClk pulse");
        end

        highCnt = 0;
        waitCnt = 0;
        while (sdClk) begin
            highCnt++;
            stepWait(waitCnt, "end of sdClk pulse");
        end
        checkValue(32'(highCnt), 32'(row.pulseTicks) * `SD_TICK_DIV, "sdClk high cycles");

        // Only DAT2 is released
        waitCnt = 0;
        while (sdDatOutEn[2]) begin
            checkValue(32'(sdClk), 32'h0, "sdClk low after pulse");
            stepWait(waitCnt, "DAT2 release");
        end
        checkValue(32'(sdDatOutEn), 32'hB, "DAT enables after release");
        checkValue(32'(sdCmdOutEn), 32'h1, "CMD enable after release");

        // A second start while busy must be ignored
        axiWrite(`REG_CTRL, 32'h1, 4'hF, 0, resp);
        @(negedge clk);
        checkValue(32'(led[0]), 32'h1, "busy LED after start while busy");

        // The run goes on without a new drive-low phase or pulse
        waitCnt = 0;
        while (!led[1]) begin
            checkValue(32'(sdDatOutEn), 32'hB, "DAT enables after start while busy");
            checkValue(32'(sdClk), 32'h0, "no new pulse after start while busy");
            stepWait(waitCnt, "done LED");
        end
        checkValue(32'(led[2]), 32'(row.expDetected), "detected LED");
        checkValue(32'(led[3]), 32'(row.cardPresent), "live DAT2 LED");

        // No further pulse once the run is finished
        repeat (2 * `SD_TICK_DIV) begin
            @(negedge clk);
            checkValue(32'(sdClk), 32'h0, "sdClk quiet after done");
            checkValue(32'(led[1:0]), 32'h2, "done held after done");
        end

        // Busy 0, done 1, detected, state DONE in bits 6:4
        expStatus = {25'd0, 3'd6, 1'b0, row.expDetected, 1'b1, 1'b0};
        drawBits(2, delay);
        axiRead(`REG_STATUS, delay, rdData, resp);
        checkValue(rdData, expStatus, "STATUS after run");
        checkValue(32'(resp), 32'h0, "STATUS read response");
        axiRead(`REG_CTRL, 0, rdData, resp);
        checkValue(rdData, 32'h0, "CTRL read back");
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        logic [31:0] rdData;
        logic [1:0]  resp;
        int          delay;
        clk         = 1'b0;
        rstN        = 1'b0;
        axiReq      = '0;
        cardPresent = 1'b0;
        lfsrState   = 32'h8107b0be;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        @(negedge clk);
        checkValue(32'({sdClk, sdCmdOutEn, sdDatOutEn}), 32'h0, "pins after reset");
        checkValue(32'(led), 32'h0, "LEDs after reset");
        checkValue(32'({axiResp.bvalid, axiResp.rvalid}), 32'h0, "responses after reset");
        drawBits(2, delay);
        axiRead(`REG_PULSE, delay, rdData, resp);
        checkValue(rdData, 32'(`LVS_PULSE_DEF), "PULSE reset value");
        drawBits(2, delay);
        axiRead(`REG_RELEASE, delay, rdData, resp);
        checkValue(rdData, 32'(`LVS_RELEASE_DEF), "RELEASE reset value");
        axiRead(`REG_STATUS, 0, rdData, resp);
        checkValue(rdData, 32'h0, "STATUS after reset");

        // Byte strobes on the low byte and then the second byte
        drawBits(2, delay);
        axiWrite(`REG_PULSE, 32'h0000_0AB5, 4'b0001, delay, resp);
        axiRead(`REG_PULSE, 0, rdData, resp);
        checkValue(rdData, 32'h0B5, "PULSE low byte write");
        axiWrite(`REG_PULSE, 32'h0000_0C00, 4'b0010, 0, resp);
        axiRead(`REG_PULSE, 0, rdData, resp);
        checkValue(rdData, 32'hCB5, "PULSE second byte write");
        axiWrite(`REG_RELEASE, 32'h0000_0333, 4'b0000, 0, resp);
        axiRead(`REG_RELEASE, 0, rdData, resp);
        checkValue(rdData, 32'(`LVS_RELEASE_DEF), "RELEASE with no strobes");
        axiWrite(`REG_PULSE, 32'h0, 4'hF, 0, resp);
        checkValue(32'(resp), 32'h0, "PULSE write response");
        axiRead(`REG_PULSE, 0, rdData, resp);
        checkValue(rdData, 32'h1, "PULSE zero stored as one");

        // Unmapped addresses and read-only STATUS
        drawBits(2, delay);
        axiRead(4'h1, delay, rdData, resp);
        checkValue(32'(resp), 32'h2, "unmapped read response");
        checkValue(rdData, 32'h0, "unmapped read data");
        axiWrite(4'h2, 32'h1234_5678, 4'hF, 0, resp);
        checkValue(32'(resp), 32'h2, "unmapped write response");
        drawBits(2, delay);
        axiWrite(`REG_STATUS, 32'hFFFF_FFFF, 4'hF, delay, resp);
        checkValue(32'(resp), 32'h0, "STATUS write response");
        axiRead(`REG_STATUS, 0, rdData, resp);
        checkValue(rdData, 32'h0, "STATUS after write");

        for (int i = 0; i < 4; i++) begin
            runRow(rows[i]);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: design/sdLvsTop.sv
`timescale 1ns/1ps

module sdLvsTop (
    input  logic                  clk,
    input  logic                  rstN,
    input  sdLvsPkg::axiLiteReqT  axiReq,
    output sdLvsPkg::axiLiteRespT axiResp,
    output logic [3:0]            led,
    output logic                  sdClk,
    output logic                  sdCmdOut,
    output logic                  sdCmdOutEn,
    output logic [3:0]            sdDatOut,
    output logic [3:0]            sdDatOutEn,
    input  logic                  sdCmdIn,
    input  logic [3:0]            sdDatIn
);
    import sdLvsPkg::*;

    logic      start;
    logic      tick;
    logic      tickRestart;
    lvsCfgT    cfg;
    lvsStatusT status;
    sdPinsT    pinsNext;
    sdPinInT   pinsIn;

    sdLvsRegs i_sdLvsRegs (
        .clk     (clk),
        .rstN    (rstN),
        .axiReq  (axiReq),
        .axiResp (axiResp),
        .start   (start),
        .cfg     (cfg),
        .status  (status)
    );

    sdTickGen i_sdTickGen (
        .clk         (clk),
        .rstN        (rstN),
        .tickRestart (tickRestart),
        .tick        (tick)
    );

    lvsSequencer i_lvsSequencer (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .cfg         (cfg),
        .tick        (tick),
        .tickRestart (tickRestart),
        .pinsIn      (pinsIn),
        .pinsNext    (pinsNext),
        .status      (status),
        .led         (led)
    );

    sdPadDriver i_sdPadDriver (
        .clk        (clk),
        .rstN       (rstN),
        .pinsNext   (pinsNext),
        .pinsIn     (pinsIn),
        .sdClk      (sdClk),
        .sdCmdOut   (sdCmdOut),
        .sdCmdOutEn (sdCmdOutEn),
        .sdDatOut   (sdDatOut),
        .sdDatOutEn (sdDatOutEn),
        .sdCmdIn    (sdCmdIn),
        .sdDatIn    (sdDatIn)
    );

endmodule

// File: design/sdLvsRegs.sv
`timescale 1ns/1ps

`include "sdLvs_config.svh"

module sdLvsRegs (
    input  logic                  clk,
    input  logic                  rstN,
    input  sdLvsPkg::axiLiteReqT  axiReq,
    output sdLvsPkg::axiLiteRespT axiResp,
    output logic                  start,
    output sdLvsPkg::lvsCfgT      cfg,
    input  sdLvsPkg::lvsStatusT   status
);

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;
    localparam logic [`LVS_CNT_W-1:0] minTicks = `LVS_CNT_W'(1);

    logic [`LVS_CNT_W-1:0] pulseReg;
    logic [`LVS_CNT_W-1:0] releaseReg;
    logic                  bvalid;
    logic                  rvalid;
    logic [1:0]            bresp;
    logic [1:0]            rresp;
    logic [31:0]           rdata;
    logic [31:0]           rdValue;
    logic                  wrFire;
    logic                  rdFire;
    logic                  wrMapped;
    logic                  rdMapped;

    // Byte-lane merge, a zero interval is stored as one tick
    function automatic logic [`LVS_CNT_W-1:0] mergeTicks(
        input logic [`LVS_CNT_W-1:0] cur,
        input logic [31:0]           data,
        input logic [3:0]            strb
    );
        logic [`LVS_CNT_W-1:0] merged;
        merged = cur;
        for (int i = 0; i < `LVS_CNT_W; i++) begin
            if (strb[i / 8]) merged[i] = data[i];
        end
        if (merged == '0) merged = minTicks;
        return merged;
    endfunction

    // ========================================================================
    // Handshakes
    // ========================================================================

    // Address and data taken together, nothing new while a response waits
    assign wrFire = axiReq.awvalid && axiReq.wvalid && !bvalid;
    assign rdFire = axiReq.arvalid && !rvalid;

    assign wrMapped = axiReq.awaddr inside {`REG_CTRL, `REG_PULSE, `REG_RELEASE, `REG_STATUS};
    assign rdMapped = axiReq.araddr inside {`REG_CTRL, `REG_PULSE, `REG_RELEASE, `REG_STATUS};

    always_comb begin
        case (axiReq.araddr)
            `REG_PULSE:   rdValue = 32'(pulseReg);
            `REG_RELEASE: rdValue = 32'(releaseReg);
            `REG_STATUS:  rdValue = {25'd0, status.state, 1'b0,
                                     status.detected, status.done, status.busy};
            // CTRL is write-only and unmapped reads return zero
            default:      rdValue = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pulseReg   <= `LVS_CNT_W'(`LVS_PULSE_DEF);
            releaseReg <= `LVS_CNT_W'(`LVS_RELEASE_DEF);
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            start      <= 1'b0;
        end else begin
            start <= wrFire && (axiReq.awaddr == `REG_CTRL)
                     && axiReq.wstrb[0] && axiReq.wdata[0];
            if (wrFire) begin
                bvalid <= 1'b1;
                case (axiReq.awaddr)
                    `REG_PULSE:   pulseReg <= mergeTicks(pulseReg, axiReq.wdata, axiReq.wstrb);
                    `REG_RELEASE: releaseReg <= mergeTicks(releaseReg, axiReq.wdata,
                                                           axiReq.wstrb);
                    default:      ;
                endcase
            end else if (bvalid && axiReq.bready) begin
                bvalid <= 1'b0;
            end
            if (rdFire) begin
                rvalid <= 1'b1;
            end else if (rvalid && axiReq.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if (wrFire) bresp <= wrMapped ? respOkay : respSlvErr;
        if (rdFire) begin
            rdata <= rdValue;
            rresp <= rdMapped ? respOkay : respSlvErr;
        end
    end

    always_comb begin
        axiResp         = '0;
        axiResp.awready = wrFire;
        axiResp.wready  = wrFire;
        axiResp.bvalid  = bvalid;
        axiResp.bresp   = bresp;
        axiResp.arready = !rvalid;
        axiResp.rvalid  = rvalid;
        axiResp.rdata   = rdata;
        axiResp.rresp   = rresp;
    end

    assign cfg = '{pulseTicks: pulseReg, releaseTicks: releaseReg};

    bvalidHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        axiResp.bvalid && !axiReq.bready |=> axiResp.bvalid && $stable(axiResp.bresp)
    );

endmodule

// File: design/lvsSequencer.sv
`timescale 1ns/1ps

`include "sdLvs_config.svh"

module lvsSequencer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  sdLvsPkg::lvsCfgT    cfg,
    input  logic                tick,
    output logic                tickRestart,
    input  sdLvsPkg::sdPinInT   pinsIn,
    output sdLvsPkg::sdPinsT    pinsNext,
    output sdLvsPkg::lvsStatusT status,
    output logic [3:0]          led
);
    import sdLvsPkg::*;

    localparam logic [`LVS_CNT_W-1:0] oneTick = `LVS_CNT_W'(1);
    // Room for the two-flop input synchronizer after DAT2 is released
    localparam logic [`LVS_CNT_W-1:0] settleTicks = `LVS_CNT_W'(2);

    lvsStateE state;
    lvsStateE stateNext;
    lvsCfgT   cfgQ;

    logic [`LVS_CNT_W-1:0] tickCnt;
    logic [`LVS_CNT_W-1:0] stepTicks;
    logic                  stepDone;
    logic                  launch;
    logic                  busy;
    logic                  done;
    logic                  detected;
    logic                  dat2Released;

    // Start is only honored between runs
    assign launch      = start && (state == IDLE || state == DONE);
    assign tickRestart = launch;

    // ========================================================================
    // Step length and state transitions
    // ========================================================================

    always_comb begin
        case (state)
            PULSE_HIGH:   stepTicks = cfgQ.pulseTicks;
            PULSE_LOW:    stepTicks = cfgQ.releaseTicks;
            RELEASE_WAIT: stepTicks = settleTicks;
            default:      stepTicks = oneTick;
        endcase
    end

    assign stepDone = tick && (tickCnt == stepTicks - 1'b1);

    always_comb begin
        stateNext = state;
        case (state)
            IDLE, DONE: begin
                if (launch) stateNext = DRIVE_LOW;
            end
            DRIVE_LOW: begin
                if (stepDone) stateNext = PULSE_HIGH;
            end
            PULSE_HIGH: begin
                if (stepDone) stateNext = PULSE_LOW;
            end
            PULSE_LOW: begin
                if (stepDone) stateNext = RELEASE_WAIT;
            end
            RELEASE_WAIT: begin
                if (stepDone) stateNext = SAMPLE;
            end
            SAMPLE:  stateNext = DONE;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= IDLE;
            tickCnt  <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
            detected <= 1'b0;
        end else begin
            state <= stateNext;
            // Each step counts its ticks from zero
            if (launch || stepDone) begin
                tickCnt <= '0;
            end else if (tick) begin
                tickCnt <= tickCnt + 1'b1;
            end
            if (launch) begin
                busy     <= 1'b1;
                done     <= 1'b0;
                detected <= 1'b0;
            end else if (state == SAMPLE) begin
                busy     <= 1'b0;
                done     <= 1'b1;
                // Card answers by pulling DAT2 high
                detected <= pinsIn.datIn[2];
            end
        end
    end

    // Interval settings are frozen for the whole run
    always_ff @(posedge clk) begin
        if (launch) cfgQ <= cfg;
    end

    // ========================================================================
    // Pins, status and LEDs
    // ========================================================================

    assign dat2Released = (state == RELEASE_WAIT) || (state == SAMPLE) || (state == DONE);

    always_comb begin
        pinsNext       = '0;
        pinsNext.sdClk = (state == PULSE_HIGH);
        if (state != IDLE) begin
            pinsNext.cmdOutEn = 1'b1;
            pinsNext.datOutEn = dat2Released ? 4'b1011 : 4'b1111;
        end
    end

    assign status = '{busy: busy, done: done, detected: detected, state: state};

    assign led = {pinsIn.datIn[2] && dat2Released, detected, done, busy};

    busyDoneExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(busy && done)
    );

    // Clock high only inside the programmed pulse while DAT2 is still held
    clkOnlyInPulse: assert property (
        @(posedge clk) disable iff (!rstN)
        pinsNext.sdClk |-> busy && pinsNext.datOutEn[2] && (tickCnt < cfgQ.pulseTicks)
    );

endmodule

// File: design/sdPadDriver.sv
`timescale 1ns/1ps

module sdPadDriver (
    input  logic              clk,
    input  logic              rstN,
    input  sdLvsPkg::sdPinsT  pinsNext,
    output sdLvsPkg::sdPinInT pinsIn,
    output logic              sdClk,
    output logic              sdCmdOut,
    output logic              sdCmdOutEn,
    output logic [3:0]        sdDatOut,
    output logic [3:0]        sdDatOutEn,
    input  logic              sdCmdIn,
    input  logic [3:0]        sdDatIn
);
    import sdLvsPkg::*;

    sdPinsT  pinsQ;
    sdPinInT syncStage1;
    sdPinInT syncStage2;

    // Output registers, one cycle behind the sequencer
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pinsQ <= '0;
        end else begin
            pinsQ <= pinsNext;
        end
    end

    assign sdClk      = pinsQ.sdClk;
    assign sdCmdOut   = pinsQ.cmdOut;
    assign sdCmdOutEn = pinsQ.cmdOutEn;
    assign sdDatOut   = pinsQ.datOut;
    assign sdDatOutEn = pinsQ.datOutEn;

    // Two-flop synchronizer on the card-driven levels
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            syncStage1 <= '0;
            syncStage2 <= '0;
        end else begin
            syncStage1 <= '{cmdIn: sdCmdIn, datIn: sdDatIn};
            syncStage2 <= syncStage1;
        end
    end

    assign pinsIn = syncStage2;

    // Host only ever pulls lines low during identification
    drivenLinesLow: assert property (
        @(posedge clk) disable iff (!rstN)
        !(sdCmdOut && sdCmdOutEn) && ((sdDatOut & sdDatOutEn) == 4'b0000)
    );

endmodule

// File: design/sdTickGen.sv
`timescale 1ns/1ps

`include "sdLvs_config.svh"

module sdTickGen (
    input  logic clk,
    input  logic rstN,
    input  logic tickRestart,
    output logic tick
);

    localparam int tickW = (`SD_TICK_DIV > 1) ? $clog2(`SD_TICK_DIV) : 1;
    localparam logic [tickW-1:0] reloadVal = tickW'(`SD_TICK_DIV - 1);

    logic [tickW-1:0] cnt;

    // Down-counter, tick on the zero count
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt <= reloadVal;
        end else if (tickRestart || cnt == '0) begin
            // Restart loads the full interval so the next step starts aligned
            cnt <= reloadVal;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    assign tick = (cnt == '0);

    // ========================================================================
    // Checks
    // ========================================================================

    // One-cycle tick, never back to back
    tickSingleCycle: assert property (
        @(posedge clk) disable iff (!rstN)
        tick |=> !tick
    );

endmodule

// File: design/sdLvsPkg.sv
`include "sdLvs_config.svh"

package sdLvsPkg;

    // Master to slave
    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axiLiteReqT;

    // Slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axiLiteRespT;

    // Host pin outputs, before the IO registers
    typedef struct packed {
        logic       sdClk;
        logic       cmdOut;
        logic       cmdOutEn;
        logic [3:0] datOut;
        logic [3:0] datOutEn;
    } sdPinsT;

    // Pin levels after the synchronizer
    typedef struct packed {
        logic       cmdIn;
        logic [3:0] datIn;
    } sdPinInT;

    typedef struct packed {
        logic [`LVS_CNT_W-1:0] pulseTicks;
        logic [`LVS_CNT_W-1:0] releaseTicks;
    } lvsCfgT;

    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        DRIVE_LOW    = 3'd1,
        PULSE_HIGH   = 3'd2,
        PULSE_LOW    = 3'd3,
        RELEASE_WAIT = 3'd4,
        SAMPLE       = 3'd5,
        DONE         = 3'd6
    } lvsStateE;

    typedef struct packed {
        logic     busy;
        logic     done;
        logic     detected;
        lvsStateE state;
    } lvsStatusT;

endpackage

// File: design/sdLvs_config.svh
`ifndef SD_LVS_CONFIG_SVH
`define SD_LVS_CONFIG_SVH

// ========================================================================
// Timing
// ========================================================================

// clk cycles per sequencer tick
`define SD_TICK_DIV 8

// Width of the tick counters and of the programmable intervals
`define LVS_CNT_W 12

// Reset values of the interval registers, in ticks
`define LVS_PULSE_DEF 7
`define LVS_RELEASE_DEF 20

// ========================================================================
// Register map
// ========================================================================

`define REG_CTRL 4'h0
`define REG_PULSE 4'h4
`define REG_RELEASE 4'h8
`define REG_STATUS 4'hC

`endif
